//--- forthCpu_consts.svh
`ifndef FORTHCPU_CONSTS_SVH
`define FORTHCPU_CONSTS_SVH

// word and address width
`define DATA_WIDTH 16

// instruction field positions
`define GROUP_MSB      15
`define GROUP_LSB      14
`define APPLY_CC_BIT   13
`define INVERT_CC_BIT  12
`define CC_SEL_MSB     11
`define CC_SEL_LSB     10
`define JUMP_MODE_MSB  9
`define JUMP_MODE_LSB  8
`define LINK_BIT       7
`define IMM_MSB        6
`define IMM_LSB        0

`define GROUP_JUMP 2'b11

// jump modes
`define MODE_ABS_REG 2'b00
`define MODE_REL_REG 2'b01
`define MODE_REL_IMM 2'b10
`define MODE_ABS_IMM 2'b11

// condition selects
`define CC_SEL_Z 2'b00
`define CC_SEL_C 2'b01
`define CC_SEL_S 2'b10
`define CC_SEL_P 2'b11

`endif

//--- forthCpuPkg.sv
`default_nettype none

`include "forthCpu_consts.svh"

package forthCpuPkg;

	typedef enum logic [2:0] {
		STOPPED,
		FETCH,
		DECODE,
		EXECUTE,
		COMMIT
	} phaseT;

	// overlays the instruction word, msb first
	typedef struct packed {
		logic [`GROUP_MSB-`GROUP_LSB:0]         group;
		logic                                   applyCc;
		logic                                   invertCc;
		logic [`CC_SEL_MSB-`CC_SEL_LSB:0]       ccSelect;
		logic [`JUMP_MODE_MSB-`JUMP_MODE_LSB:0] jumpMode;
		logic                                   link;
		logic [`IMM_MSB-`IMM_LSB:0]             immOffset;
	} instrFieldsT;

	typedef struct packed {
		logic zero;
		logic carry;
		logic sign;
		logic parity;
	} ccFlagsT;

	typedef enum logic {BASE_PC, BASE_ZERO} pcBaseT;

	typedef enum logic [1:0] {OFF_TWO, OFF_REGB, OFF_IMM} pcOffsetT;

	typedef struct packed {
		pcBaseT                     base;
		pcOffsetT                   offset;
		logic [`IMM_MSB-`IMM_LSB:0] imm; // unscaled word offset
	} pcControlT;

endpackage

`default_nettype wire

//--- instructionPhaseDecoder.sv
`default_nettype none

`include "forthCpu_consts.svh"

module instructionPhaseDecoder (
	input  wire                          CLK,
	input  wire                          reset,
	input  wire  [`DATA_WIDTH-1:0]       din,
	input  wire                          halt,
	input  wire                          debugStop,
	input  wire                          debugStepReq,
	output forthCpuPkg::phaseT           phase,
	output forthCpuPkg::instrFieldsT     instruction,
	output logic                         debugActive,
	output logic                         debugStepAck
);

	logic stepping; // one instruction released from debug stop

	always_ff @(posedge CLK) begin
		if (reset) begin
			phase <= forthCpuPkg::FETCH;
			debugActive <= 1'b0;
			debugStepAck <= 1'b0;
			stepping <= 1'b0;
		end else begin
			debugStepAck <= 1'b0;
			case (phase)
				forthCpuPkg::FETCH: phase <= forthCpuPkg::DECODE;
				forthCpuPkg::DECODE: phase <= forthCpuPkg::EXECUTE;
				forthCpuPkg::EXECUTE: begin
					phase <= forthCpuPkg::COMMIT;
					debugStepAck <= stepping; // ack sits on the stepped commit
					stepping <= 1'b0;
				end
				forthCpuPkg::COMMIT: begin
					if (halt) begin
						phase <= forthCpuPkg::STOPPED; // only reset gets out of here
						debugActive <= 1'b0;
					end else if (debugStop) begin
						phase <= forthCpuPkg::STOPPED;
						debugActive <= 1'b1;
					end else begin
						phase <= forthCpuPkg::FETCH;
						debugActive <= 1'b0;
					end
				end
				default: begin
					if (debugActive && !debugStop) begin
						phase <= forthCpuPkg::FETCH; // resume
						debugActive <= 1'b0;
					end else if (debugActive && debugStepReq) begin
						phase <= forthCpuPkg::FETCH;
						stepping <= 1'b1;
					end
				end
			endcase
		end
	end

	// instruction register
	always_ff @(posedge CLK) begin
		if (phase == forthCpuPkg::FETCH) begin
			instruction.group <= din[`GROUP_MSB:`GROUP_LSB];
			instruction.applyCc <= din[`APPLY_CC_BIT];
			instruction.invertCc <= din[`INVERT_CC_BIT];
			instruction.ccSelect <= din[`CC_SEL_MSB:`CC_SEL_LSB];
			instruction.jumpMode <= din[`JUMP_MODE_MSB:`JUMP_MODE_LSB];
			instruction.link <= din[`LINK_BIT];
			instruction.immOffset <= din[`IMM_MSB:`IMM_LSB];
		end
	end

	stoppedHolds: assert property (@(posedge CLK) disable iff (reset)
		phase == forthCpuPkg::STOPPED && !(debugActive && (debugStepReq || !debugStop))
		|=> phase == forthCpuPkg::STOPPED);

	ackOnlyInDebug: assert property (@(posedge CLK) disable iff (reset)
		debugStepAck |-> debugActive && phase == forthCpuPkg::COMMIT);

endmodule

`default_nettype wire

//--- conditionFlags.sv
`default_nettype none

module conditionFlags (
	input  wire                      CLK,
	input  wire                      reset,
	input  wire forthCpuPkg::ccFlagsT flagsIn,
	input  wire                      flagsWrite,
	output forthCpuPkg::ccFlagsT     flags
);

	always_ff @(posedge CLK) begin
		if (reset) begin
			flags <= '0;
		end else if (flagsWrite) begin
			flags <= flagsIn; // visible to the decoder from the next cycle
		end
	end

	// the jump decoder only ever sees values that came through the strobe
	flagsHeld: assert property (@(posedge CLK) disable iff (reset)
		!$past(flagsWrite) && !$past(reset) |-> $stable(flags));

endmodule

`default_nettype wire

//--- jumpGroupDecoder.sv
`default_nettype none

`include "forthCpu_consts.svh"

module jumpGroupDecoder (
	input  wire                           CLK,
	input  wire                           reset,
	input  wire forthCpuPkg::phaseT       phase,
	input  wire forthCpuPkg::instrFieldsT instruction,
	input  wire forthCpuPkg::ccFlagsT     flags,
	output forthCpuPkg::pcControlT        pcControl,
	output logic                          linkRequest
);

	logic selectedFlag;
	logic taken;

	always_comb begin
		case (instruction.ccSelect)
			`CC_SEL_Z: selectedFlag = flags.zero;
			`CC_SEL_C: selectedFlag = flags.carry;
			`CC_SEL_S: selectedFlag = flags.sign;
			`CC_SEL_P: selectedFlag = flags.parity;
			default: selectedFlag = 1'b0;
		endcase
	end

	// unconditional unless applyCc, invertCc flips the sense
	assign taken = (instruction.group == `GROUP_JUMP)
		&& (!instruction.applyCc || (selectedFlag ^ instruction.invertCc));

	always_ff @(posedge CLK) begin
		if (reset) begin
			pcControl.base <= forthCpuPkg::BASE_PC;
			pcControl.offset <= forthCpuPkg::OFF_TWO;
			pcControl.imm <= '0;
			linkRequest <= 1'b0;
		end else if (phase == forthCpuPkg::EXECUTE) begin
			pcControl.imm <= instruction.immOffset;
			linkRequest <= taken && instruction.link;
			if (!taken) begin
				pcControl.base <= forthCpuPkg::BASE_PC; // fall through
				pcControl.offset <= forthCpuPkg::OFF_TWO;
			end else begin
				case (instruction.jumpMode)
					`MODE_ABS_REG: begin
						pcControl.base <= forthCpuPkg::BASE_ZERO;
						pcControl.offset <= forthCpuPkg::OFF_REGB;
					end
					`MODE_REL_REG: begin
						pcControl.base <= forthCpuPkg::BASE_PC;
						pcControl.offset <= forthCpuPkg::OFF_REGB;
					end
					`MODE_REL_IMM: begin
						pcControl.base <= forthCpuPkg::BASE_PC;
						pcControl.offset <= forthCpuPkg::OFF_IMM;
					end
					default: begin // MODE_ABS_IMM
						pcControl.base <= forthCpuPkg::BASE_ZERO;
						pcControl.offset <= forthCpuPkg::OFF_IMM;
					end
				endcase
			end
		end
	end

	// programCounter reads pcControl during COMMIT, so it must be settled by then
	controlOnlyFromExecute: assert property (@(posedge CLK) disable iff (reset)
		!$past(reset) && $past(phase) != forthCpuPkg::EXECUTE
		|-> $stable(pcControl) && $stable(linkRequest));

endmodule

`default_nettype wire

//--- programCounter.sv
`default_nettype none

`include "forthCpu_consts.svh"

module programCounter (
	input  wire                         CLK,
	input  wire                         reset,
	input  wire forthCpuPkg::phaseT     phase,
	input  wire forthCpuPkg::pcControlT pcControl,
	input  wire [`DATA_WIDTH-1:0]       regBValue,
	output logic [`DATA_WIDTH-1:0]      pc,
	output logic [`DATA_WIDTH-1:0]      linkAddress
);

	localparam int ImmWidth = `IMM_MSB - `IMM_LSB + 1;
	localparam logic [`DATA_WIDTH-1:0] PcStep = 2; // one instruction word in bytes

	logic [`DATA_WIDTH-1:0] baseValue;
	logic [`DATA_WIDTH-1:0] immValue;
	logic [`DATA_WIDTH-1:0] offsetValue;
	logic [`DATA_WIDTH-1:0] nextPc;

	// pc based offsets are signed, absolute ones are not
	always_comb begin
		if (pcControl.base == forthCpuPkg::BASE_PC) begin
			baseValue = pc;
			immValue = {{(`DATA_WIDTH-ImmWidth){pcControl.imm[ImmWidth-1]}}, pcControl.imm};
		end else begin
			baseValue = '0;
			immValue = {{(`DATA_WIDTH-ImmWidth){1'b0}}, pcControl.imm};
		end
	end

	always_comb begin
		case (pcControl.offset)
			forthCpuPkg::OFF_REGB: offsetValue = regBValue;
			forthCpuPkg::OFF_IMM: offsetValue = immValue << 1; // words to bytes
			default: offsetValue = PcStep;
		endcase
	end

	assign nextPc = baseValue + offsetValue;
	assign linkAddress = pc + PcStep;

	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= '0;
		end else if (phase == forthCpuPkg::COMMIT) begin
			pc <= {nextPc[`DATA_WIDTH-1:1], 1'b0};
		end
	end

	pcAligned: assert property (@(posedge CLK) disable iff (reset) pc[0] == 1'b0);

endmodule

`default_nettype wire

//--- jumpUnitTop.sv
`default_nettype none

`include "forthCpu_consts.svh"

module jumpUnitTop (
	input  wire                       CLK,
	input  wire                       reset,
	input  wire  [`DATA_WIDTH-1:0]    din,
	input  wire  [`DATA_WIDTH-1:0]    regBValue,
	input  wire forthCpuPkg::ccFlagsT flagsIn,
	input  wire                       flagsWrite,
	input  wire                       halt,
	input  wire                       debugStop,
	input  wire                       debugStepReq,
	output logic [`DATA_WIDTH-1:0]    pc,
	output forthCpuPkg::phaseT        phase,
	output forthCpuPkg::instrFieldsT  instruction,
	output logic                      linkWrite,
	output logic [`DATA_WIDTH-1:0]    linkAddress,
	output logic                      debugActive,
	output logic                      debugStepAck
);

	forthCpuPkg::ccFlagsT flags;
	forthCpuPkg::pcControlT pcControl;
	logic linkRequest;

	instructionPhaseDecoder u_instructionPhaseDecoder (
		.CLK(CLK),
		.reset(reset),
		.din(din),
		.halt(halt),
		.debugStop(debugStop),
		.debugStepReq(debugStepReq),
		.phase(phase),
		.instruction(instruction),
		.debugActive(debugActive),
		.debugStepAck(debugStepAck)
	);

	conditionFlags u_conditionFlags (
		.CLK(CLK),
		.reset(reset),
		.flagsIn(flagsIn),
		.flagsWrite(flagsWrite),
		.flags(flags)
	);

	jumpGroupDecoder u_jumpGroupDecoder (
		.CLK(CLK),
		.reset(reset),
		.phase(phase),
		.instruction(instruction),
		.flags(flags),
		.pcControl(pcControl),
		.linkRequest(linkRequest)
	);

	programCounter u_programCounter (
		.CLK(CLK),
		.reset(reset),
		.phase(phase),
		.pcControl(pcControl),
		.regBValue(regBValue),
		.pc(pc),
		.linkAddress(linkAddress)
	);

	assign linkWrite = linkRequest && (phase == forthCpuPkg::COMMIT); // pc still pre-commit here

endmodule

`default_nettype wire

//--- tb_jumpUnit.sv
`default_nettype none

`include "forthCpu_consts.svh"

module tb_jumpUnit;

	logic CLK = 1'b0;
	logic reset;
	wire [`DATA_WIDTH-1:0] din;
	logic [`DATA_WIDTH-1:0] regBValue;
	forthCpuPkg::ccFlagsT flagsIn;
	logic flagsWrite;
	logic halt;
	logic debugStop;
	logic debugStepReq;
	wire [`DATA_WIDTH-1:0] pc;
	forthCpuPkg::phaseT phase;
	forthCpuPkg::instrFieldsT instruction;
	wire linkWrite;
	wire [`DATA_WIDTH-1:0] linkAddress;
	wire debugActive;
	wire debugStepAck;

	logic [`DATA_WIDTH-1:0] mem [0:63];
	logic [`DATA_WIDTH-1:0] modelPc;
	logic [31:0] rngState = 32'd91569;
	logic [31:0] fillRand;
	logic debugStopLevel = 1'b0; // applied at the end of the next FETCH
	logic haltLevel = 1'b0;
	int checks = 0;
	int errors = 0;
	int testStart = 0;

	jumpUnitTop u_jumpUnitTop (
		.CLK(CLK), .reset(reset), .din(din), .regBValue(regBValue),
		.flagsIn(flagsIn), .flagsWrite(flagsWrite), .halt(halt),
		.debugStop(debugStop), .debugStepReq(debugStepReq), .pc(pc),
		.phase(phase), .instruction(instruction), .linkWrite(linkWrite),
		.linkAddress(linkAddress), .debugActive(debugActive),
		.debugStepAck(debugStepAck)
	);

	always #20 CLK = ~CLK;

	assign din = mem[pc[6:1]]; // memory answers within FETCH

	function automatic logic [31:0] xorshift32();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	task automatic checkVal(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("ERR %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic finishTest(input string name);
		$display("test %s done with %0d errors", name, errors - testStart);
		testStart = errors;
	endtask

	task automatic waitFetch();
		int n;
		n = 0;
		while (phase != forthCpuPkg::FETCH && n < 50) begin
			@(negedge CLK);
			n++;
		end
		if (phase != forthCpuPkg::FETCH) begin
			$display("timed out waiting for the FETCH phase");
			$display("TESTBENCH FAILED");
			$finish;
		end
	endtask

	// stimMode 1 forces a fall through and stimMode 2 the link bit
	task automatic runInstr(input int stimMode, input logic expectAck);
		logic [31:0] r;
		logic [15:0] w;
		logic [15:0] rb;
		logic [15:0] target;
		forthCpuPkg::ccFlagsT f;
		logic flag;
		logic taken;
		logic doLink;
		waitFetch();
		checkVal("pc", pc, modelPc);
		r = xorshift32();
		f = r[3:0];
		rb = r[31:16] & 16'hFFFE; // even operand
		w = mem[modelPc[6:1]];
		case (w[11:10])
			`CC_SEL_Z: flag = f.zero;
			`CC_SEL_C: flag = f.carry;
			`CC_SEL_S: flag = f.sign;
			default: flag = f.parity;
		endcase
		if (stimMode == 1 && r[4]) begin
			w[15:14] = (r[6:5] == `GROUP_JUMP) ? 2'b00 : r[6:5];
		end else if (stimMode == 1) begin
			w[15:14] = `GROUP_JUMP;
			w[13] = 1'b1;
			w[12] = flag; // condition evaluates false
		end
		if (stimMode == 2) begin
			w[7] = 1'b1;
		end
		mem[modelPc[6:1]] = w;
		taken = (w[15:14] == `GROUP_JUMP) && (!w[13] || (flag ^ w[12]));
		case (w[9:8])
			`MODE_ABS_REG: target = rb;
			`MODE_REL_REG: target = modelPc + rb;
			`MODE_REL_IMM: target = modelPc + {{8{w[6]}}, w[6:0], 1'b0};
			default: target = {8'h00, w[6:0], 1'b0};
		endcase
		if (!taken) begin
			target = modelPc + 16'd2;
		end
		target[0] = 1'b0;
		doLink = taken && w[7];
		@(posedge CLK);
		flagsIn <= f;
		flagsWrite <= 1'b1;
		regBValue <= rb;
		debugStop <= debugStopLevel;
		halt <= haltLevel;
		@(negedge CLK);
		checkVal("phase", phase, forthCpuPkg::DECODE);
		checkVal("instruction", instruction, w);
		checkVal("linkWrite", linkWrite, 1'b0);
		@(posedge CLK);
		flagsWrite <= 1'b0;
		@(negedge CLK);
		checkVal("phase", phase, forthCpuPkg::EXECUTE);
		checkVal("linkWrite", linkWrite, 1'b0);
		checkVal("debugStepAck", debugStepAck, 1'b0);
		@(negedge CLK);
		checkVal("phase", phase, forthCpuPkg::COMMIT);
		checkVal("linkWrite", linkWrite, doLink);
		checkVal("linkAddress", linkAddress, modelPc + 16'd2);
		checkVal("debugStepAck", debugStepAck, expectAck);
		@(negedge CLK);
		modelPc = target;
		checkVal("pc", pc, modelPc);
	endtask

	initial begin
		reset = 1'b1;
		regBValue = '0;
		flagsIn = '0;
		flagsWrite = 1'b0;
		halt = 1'b0;
		debugStop = 1'b0;
		debugStepReq = 1'b0;
		modelPc = '0;
		for (int i = 0; i < 64; i++) begin
			fillRand = xorshift32();
			mem[i] = fillRand[15:0];
			if (fillRand[16]) mem[i][15:14] = `GROUP_JUMP; // about half are jumps
		end
		repeat (16) @(posedge CLK);
		reset <= 1'b0;
		@(negedge CLK);
		checkVal("phase", phase, forthCpuPkg::FETCH);
		checkVal("pc", pc, 16'h0000);
		checkVal("linkWrite", linkWrite, 1'b0);
		checkVal("debugActive", debugActive, 1'b0);
		checkVal("debugStepAck", debugStepAck, 1'b0);
		runInstr(0, 1'b0);
		checkVal("phase", phase, forthCpuPkg::FETCH);
		finishTest("reset state");
		repeat (40) runInstr(1, 1'b0);
		finishTest("non-jump advance");
		repeat (200) runInstr(0, 1'b0);
		finishTest("jump modes");
		repeat (60) runInstr(2, 1'b0);
		finishTest("link");
		debugStopLevel = 1'b1;
		runInstr(0, 1'b0);
		checkVal("phase", phase, forthCpuPkg::STOPPED);
		checkVal("debugActive", debugActive, 1'b1);
		repeat (6) begin
			@(posedge CLK);
			debugStepReq <= 1'b1;
			@(posedge CLK);
			debugStepReq <= 1'b0;
			@(negedge CLK);
			runInstr(0, 1'b1);
			checkVal("phase", phase, forthCpuPkg::STOPPED);
			checkVal("debugActive", debugActive, 1'b1);
			checkVal("debugStepAck", debugStepAck, 1'b0);
		end
		debugStopLevel = 1'b0;
		@(posedge CLK);
		debugStop <= 1'b0; // resume
		@(negedge CLK);
		runInstr(0, 1'b0);
		checkVal("phase", phase, forthCpuPkg::FETCH);
		checkVal("debugActive", debugActive, 1'b0);
		finishTest("debug");
		haltLevel = 1'b1;
		runInstr(0, 1'b0);
		repeat (20) begin
			checkVal("phase", phase, forthCpuPkg::STOPPED);
			checkVal("pc", pc, modelPc);
			@(negedge CLK);
		end
		finishTest("halt");
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
forthCpuPkg.sv
instructionPhaseDecoder.sv
conditionFlags.sv
jumpGroupDecoder.sv
programCounter.sv
jumpUnitTop.sv
tb_jumpUnit.sv

//--- Bender.yml
package:
  name: forth_cpu_jump_unit

sources:
  - include_dirs:
      - .
    files:
      - forthCpuPkg.sv
      - instructionPhaseDecoder.sv
      - conditionFlags.sv
      - jumpGroupDecoder.sv
      - programCounter.sv
      - jumpUnitTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_jumpUnit.sv
